// ==== project.f ====
source/spi_ctrl_pkg.sv
source/pin_conditioner.sv
source/spi_byte_engine.sv
source/ctrl_reg_block.sv
source/mcu_ctrl_top.sv
dv/mcu_ctrl_assert.sv
dv/tb_mcu_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator and run, the exit status of the simulation is the result
cd "$(dirname "$0")" \
	&& verilator --binary --assert -j 0 --top-module tb_mcu_ctrl -f project.f \
	&& ./obj_dir/Vtb_mcu_ctrl \
	|| exit 1

// ==== dv/tb_mcu_ctrl.sv ====
// mode 0 master at 8 clk_sys per half sck; WD_LIMIT of 200 keeps the watchdog test short
`timescale 1ns/100ps
`default_nettype none

module tb_mcu_ctrl;

	import spi_ctrl_pkg::*;

	localparam int HALF = 8;
	// 13 frames of up to 3 bytes of 16 half periods, frame gaps, the 400 cycle pause, reset
	localparam int TEST_CYCLES    = 40 * 16 * HALF + 14 * 60 + 400 + 20;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic        clk_sys;
	logic        rst_n;
	logic        mcu_csn;
	logic        mcu_sck;
	logic        mcu_mosi;
	logic        mcu_miso;
	ctrl_regs_t  ctrl_regs;
	ctrl_regs_t  exp_regs;
	int          cycle_cnt;

	mcu_ctrl_top #(
		.WD_LIMIT (200)
	) UUT (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.mcu_csn   (mcu_csn),
		.mcu_sck   (mcu_sck),
		.mcu_mosi  (mcu_mosi),
		.mcu_miso  (mcu_miso),
		.ctrl_regs (ctrl_regs)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	// ----------------------------------------
	// compare tasks and register model

	task automatic compare_byte(input string name, input logic [7:0] exp_val,
			input logic [7:0] act_val);
		if (act_val !== exp_val) begin
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp_val, act_val);
			$display("TEST FAIL");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic compare_regs(input ctrl_regs_t exp_val, input ctrl_regs_t act_val);
		if (act_val !== exp_val) begin
			$display("[FAIL] %0t ns ctrl_regs expected %h got %h", $time, exp_val, act_val);
			$display("TEST FAIL");
			$fatal(1, "register mismatch");
		end
	endtask

	// only valid write commands to address 1 to 3 land
	function automatic ctrl_regs_t apply_write(input ctrl_regs_t regs, input logic [7:0] cmd,
			input logic [7:0] data);
		ctrl_regs_t nxt;
		nxt = regs;
		if (cmd[CMD_WRITE_BIT] && cmd[6:2] == 5'd0) begin
			case (cmd[1:0])
				ADDR_CTRL1: nxt.ctrl1 = data;
				ADDR_CTRL2: nxt.ctrl2 = data;
				ADDR_CTRL3: nxt.ctrl3 = data;
				default: ;
			endcase
		end
		return nxt;
	endfunction

	function automatic logic [7:0] expected_read(input logic [1:0] addr);
		case (addr)
			ADDR_CTRL1: return exp_regs.ctrl1;
			ADDR_CTRL2: return exp_regs.ctrl2;
			ADDR_CTRL3: return exp_regs.ctrl3;
			default: return DEV_ID;
		endcase
	endfunction

	// ----------------------------------------
	// SPI master

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	// msb first with miso taken half a clk_sys before each sck rise
	task automatic shift_bits(input logic [7:0] tx_val, input int nbits,
			output logic [7:0] rx_val);
		logic [7:0] sh;
		sh     = tx_val;
		rx_val = 8'hFF;
		repeat (nbits) begin
			mcu_mosi <= sh[7];
			sh = {sh[6:0], 1'b0};
			wait_cycles(HALF - 1);
			@(negedge clk_sys);
			rx_val = {rx_val[6:0], mcu_miso};
			@(posedge clk_sys);
			mcu_sck <= 1'b1;
			wait_cycles(HALF);
			mcu_sck <= 1'b0;
		end
	endtask

	task automatic spi_xfer(input logic [7:0] tx_val, output logic [7:0] rx_val);
		shift_bits(tx_val, 8, rx_val);
	endtask

	task automatic frame_open();
		mcu_csn <= 1'b0;
		wait_cycles(HALF);
	endtask

	task automatic frame_close();
		wait_cycles(HALF);
		mcu_csn  <= 1'b1;
		mcu_mosi <= 1'b0;
		wait_cycles(2 * HALF);
	endtask

	task automatic check_regs();
		wait_cycles(20);
		@(negedge clk_sys);
		compare_regs(exp_regs, ctrl_regs);
		@(posedge clk_sys);
	endtask

	// command, data and one extra byte while miso stays at the id
	task automatic write_frame(input logic [7:0] cmd, input logic [7:0] data);
		logic [7:0] rx_val;
		frame_open();
		spi_xfer(cmd, rx_val);
		compare_byte("miso command byte", DEV_ID, rx_val);
		spi_xfer(data, rx_val);
		compare_byte("miso data byte", DEV_ID, rx_val);
		spi_xfer(~data, rx_val);
		compare_byte("miso extra byte", DEV_ID, rx_val);
		frame_close();
		exp_regs = apply_write(exp_regs, cmd, data);
		check_regs();
	endtask

	task automatic read_frame(input logic [1:0] addr);
		logic [7:0] rx_val;
		frame_open();
		spi_xfer({6'd0, addr}, rx_val);
		compare_byte("miso command byte", DEV_ID, rx_val);
		spi_xfer(8'h00, rx_val);
		compare_byte("miso read data", expected_read(addr), rx_val);
		spi_xfer(8'h00, rx_val);
		compare_byte("miso extra byte", DEV_ID, rx_val);
		frame_close();
	endtask

	// ----------------------------------------
	// directed tests

	task automatic check_after_reset();
		check_regs();
		read_frame(ADDR_ID);
	endtask

	task automatic write_read_all();
		for (int a = 1; a < 4; a++)
			write_frame({1'b1, 5'd0, 2'(a)}, 8'($urandom()));
		for (int a = 1; a < 4; a++)
			read_frame(2'(a));
	endtask

	task automatic ignored_writes();
		write_frame({1'b1, 5'd0, ADDR_ID}, 8'h5A);
		// bit 6 set makes the command invalid
		write_frame({1'b1, 5'b10000, ADDR_CTRL1}, ~exp_regs.ctrl1);
		read_frame(ADDR_ID);
	endtask

	task automatic aborted_frame();
		logic [7:0] rx_val;
		frame_open();
		shift_bits({1'b1, 5'd0, ADDR_CTRL2}, 5, rx_val);
		frame_close();
		check_regs();
		write_frame({1'b1, 5'd0, ADDR_CTRL2}, ~exp_regs.ctrl2);
	endtask

	// without the watchdog the stray ones would turn the command into an invalid byte
	task automatic watchdog_realign();
		logic [7:0] rx_val;
		logic [7:0] data;
		data = ~exp_regs.ctrl3;
		frame_open();
		shift_bits(8'hFF, 3, rx_val);
		wait_cycles(400);
		spi_xfer({1'b1, 5'd0, ADDR_CTRL3}, rx_val);
		spi_xfer(data, rx_val);
		frame_close();
		exp_regs = apply_write(exp_regs, {1'b1, 5'd0, ADDR_CTRL3}, data);
		check_regs();
	endtask

	initial begin
		void'($urandom(15));
		exp_regs = '0;
		rst_n    <= 1'b0;
		mcu_csn  <= 1'b1;
		mcu_sck  <= 1'b0;
		mcu_mosi <= 1'b0;
		wait_cycles(16);
		rst_n <= 1'b1;
		wait_cycles(4);
		check_after_reset();
		write_read_all();
		ignored_writes();
		aborted_frame();
		watchdog_realign();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/mcu_ctrl_assert.sv ====
// bound into every spi_byte_engine; expects rst_n to be released on a rising clk_sys edge
`timescale 1ns/100ps
`default_nettype none

module mcu_ctrl_assert (
	input wire                         clk_sys,
	input wire                         rst_n,
	input wire spi_ctrl_pkg::pin_evt_t evt,
	input wire spi_ctrl_pkg::rx_byte_t rx,
	input wire                         miso
);

	// byte strobe is a single pulse
	rx_vld_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rx.vld |=> !rx.vld)
		else $error("rx vld stayed high for more than one cycle");

	// no byte is delivered outside a frame, the whole byte delay lies inside it
	rx_vld_in_frame: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rx.vld |-> !evt.csn && !$past(evt.csn) && !$past(evt.csn, 2))
		else $error("rx vld high while csn is high or was high during the byte delay");

	// miso idles high under reset
	miso_idle_reset: assert property (@(posedge clk_sys)
		!rst_n |=> miso)
		else $error("miso not high during reset");

endmodule

bind spi_byte_engine mcu_ctrl_assert u_assert (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.evt     (evt),
	.rx      (rx),
	.miso    (miso)
);

`default_nettype wire

// ==== source/mcu_ctrl_top.sv ====
// mode 0 SPI slave for slow links only; WD_LIMIT must suit the clk_sys frequency
`timescale 1ns/100ps
`default_nettype none

module mcu_ctrl_top #(
	parameter int unsigned WD_LIMIT = 1_000_000
) (
	input  wire                           clk_sys,
	input  wire                           rst_n,
	input  wire                           mcu_csn,
	input  wire                           mcu_sck,
	input  wire                           mcu_mosi,
	output wire                           mcu_miso,
	output wire spi_ctrl_pkg::ctrl_regs_t ctrl_regs
);

	import spi_ctrl_pkg::*;

	pin_evt_t   evt;
	rx_byte_t   rx;
	logic [7:0] reply_byte;

	// ----------------------------------------
	// pins to events, events to bytes, bytes to registers

	pin_conditioner u_pins (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.csn_pin  (mcu_csn),
		.sck_pin  (mcu_sck),
		.mosi_pin (mcu_mosi),
		.evt      (evt)
	);

	spi_byte_engine #(
		.WD_LIMIT (WD_LIMIT)
	) u_engine (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.evt        (evt),
		.reply_byte (reply_byte),
		.rx         (rx),
		.miso       (mcu_miso)
	);

	ctrl_reg_block u_regs (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rx         (rx),
		.reply_byte (reply_byte),
		.ctrl_regs  (ctrl_regs)
	);

endmodule

`default_nettype wire

// ==== source/ctrl_reg_block.sv ====
// two byte frames only; bytes past the second and bytes without a command are ignored
`timescale 1ns/100ps
`default_nettype none

module ctrl_reg_block (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire spi_ctrl_pkg::rx_byte_t rx,
	output logic [7:0]                  reply_byte,
	output spi_ctrl_pkg::ctrl_regs_t    ctrl_regs
);

	import spi_ctrl_pkg::*;

	// idle also covers a discarded frame until the next command
	typedef enum logic {
		ST_IDLE,
		ST_WRITE
	} state_t;

	state_t     state;
	logic [1:0] wr_addr;
	logic       cmd_ok;
	logic       cmd_wr;
	logic [7:0] rd_val;

	// ----------------------------------------
	// command decode

	assign cmd_ok = (rx.data[6:2] == 5'd0);
	assign cmd_wr = rx.data[CMD_WRITE_BIT];

	always_comb begin
		case (rx.data[1:0])
			ADDR_ID:    rd_val = DEV_ID;
			ADDR_CTRL1: rd_val = ctrl_regs.ctrl1;
			ADDR_CTRL2: rd_val = ctrl_regs.ctrl2;
			ADDR_CTRL3: rd_val = ctrl_regs.ctrl3;
		endcase
	end

	// address of a pending write
	always_ff @(posedge clk_sys) begin
		if (rx.vld && rx.first)
			wr_addr <= rx.data[1:0];
	end

	// ----------------------------------------
	// frame FSM and register file

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			reply_byte <= DEV_ID;
			ctrl_regs  <= '0;
		end else if (rx.vld) begin
			// every byte hands the reply back to the id unless a read asks otherwise
			reply_byte <= DEV_ID;
			state      <= ST_IDLE;
			if (rx.first) begin
				if (cmd_ok && cmd_wr)
					state <= ST_WRITE;
				else if (cmd_ok)
					reply_byte <= rd_val;
			end else if (state == ST_WRITE) begin
				case (wr_addr)
					ADDR_CTRL1: ctrl_regs.ctrl1 <= rx.data;
					ADDR_CTRL2: ctrl_regs.ctrl2 <= rx.data;
					ADDR_CTRL3: ctrl_regs.ctrl3 <= rx.data;
					// id register is read only
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/spi_byte_engine.sv ====
// mode 0 only, msb first; WD_LIMIT is in clk_sys cycles and must be at least 1
`timescale 1ns/100ps
`default_nettype none

module spi_byte_engine #(
	parameter int unsigned WD_LIMIT = 1_000_000
) (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire spi_ctrl_pkg::pin_evt_t evt,
	input  wire [7:0]                   reply_byte,
	output spi_ctrl_pkg::rx_byte_t      rx,
	output logic                        miso
);

	import spi_ctrl_pkg::*;

	logic [2:0]                      bit_cnt;
	logic [2:0]                      bit_cnt_q;
	logic [$clog2(WD_LIMIT + 1)-1:0] wd_cnt;
	logic                            wd_keep;
	logic                            wd_fire;
	logic [7:0]                      rx_sh;
	logic                            byte_done;
	logic [1:0]                      done_dly;
	logic                            rx_vld;
	logic                            first_flag;
	logic [7:0]                      tx_sh;
	logic [7:0]                      reply_q;
	logic                            reply_chg;
	logic                            open_dly;
	logic                            tx_shift;

	// ----------------------------------------
	// bit counter and watchdog

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt   <= 3'd0;
			bit_cnt_q <= 3'd0;
			wd_cnt    <= '0;
		end else begin
			bit_cnt_q <= bit_cnt;
			if (evt.csn)
				bit_cnt <= 3'd0;
			else if (wd_fire)
				bit_cnt <= 3'd0;
			else if (evt.sck_rise)
				bit_cnt <= bit_cnt + 3'd1;
			if (wd_keep)
				wd_cnt <= wd_cnt + 1'b1;
			else
				wd_cnt <= '0;
		end
	end

	// half received byte that has stalled
	assign wd_keep = (bit_cnt == bit_cnt_q) && (bit_cnt != 3'd0);
	assign wd_fire = (32'(wd_cnt) == WD_LIMIT);

	// ----------------------------------------
	// receive path

	always_ff @(posedge clk_sys) begin
		if (evt.sck_rise)
			rx_sh <= {rx_sh[6:0], evt.mosi};
	end

	assign byte_done = evt.sck_rise && (bit_cnt == 3'd7);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			done_dly   <= 2'b00;
			first_flag <= 1'b0;
		end else begin
			done_dly <= {done_dly[0], byte_done};
			if (evt.csn)
				first_flag <= 1'b0;
			else if (evt.csn_fall)
				first_flag <= 1'b1;
			else if (rx_vld)
				first_flag <= 1'b0;
		end
	end

	// a frame closing under the delay drops the byte
	assign rx_vld = done_dly[1] & ~evt.csn;

	always_comb begin
		rx.vld   = rx_vld;
		rx.first = first_flag;
		rx.data  = rx_sh;
	end

	// ----------------------------------------
	// transmit path

	assign reply_chg = (reply_byte != reply_q);

	// frame start acts as an extra fall so bit 7 is out before the first rise
	assign tx_shift = evt.sck_fall | open_dly;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			reply_q  <= DEV_ID;
			open_dly <= 1'b0;
			tx_sh    <= 8'hFF;
			miso     <= 1'b1;
		end else begin
			reply_q  <= reply_byte;
			open_dly <= evt.csn_fall;
			if (evt.csn_fall || rx_vld || reply_chg)
				tx_sh <= reply_byte;
			else if (tx_shift)
				tx_sh <= {tx_sh[6:0], 1'b1};
			if (tx_shift)
				miso <= tx_sh[7];
		end
	end

endmodule

`default_nettype wire

// ==== source/pin_conditioner.sv ====
// pins must idle with csn high and sck low in reset; pulses under 3 clk_sys cycles are lost
`timescale 1ns/100ps
`default_nettype none

module pin_conditioner (
	input  wire                    clk_sys,
	input  wire                    rst_n,
	input  wire                    csn_pin,
	input  wire                    sck_pin,
	input  wire                    mosi_pin,
	output spi_ctrl_pkg::pin_evt_t evt
);

	// bit 0 csn, bit 1 sck, bit 2 mosi
	logic [2:0] pins;
	logic [2:0] sync1;
	logic [2:0] sync2;
	logic [2:0] hist1;
	logic [2:0] hist2;
	logic [2:0] held;
	logic [2:0] all_hi;
	logic [2:0] all_lo;
	logic [2:0] filt;

	assign pins = {mosi_pin, sck_pin, csn_pin};

	// ----------------------------------------
	// synchroniser and sample history

	// reset to the idle pin levels so no edge fires out of reset
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= 3'b001;
			sync2 <= 3'b001;
			hist1 <= 3'b001;
			hist2 <= 3'b001;
			held  <= 3'b001;
		end else begin
			sync1 <= pins;
			sync2 <= sync1;
			hist1 <= sync2;
			hist2 <= hist1;
			held  <= filt;
		end
	end

	// ----------------------------------------
	// three sample agreement

	assign all_hi = sync2 & hist1 & hist2;
	assign all_lo = ~(sync2 | hist1 | hist2);

	// keep last agreed level until all three samples agree again
	assign filt = all_hi | (held & ~all_lo);

	// strobes line up with the cycle the filtered level moves
	always_comb begin
		evt.csn      = filt[0];
		evt.csn_fall = held[0] & ~filt[0];
		evt.sck_rise = filt[1] & ~held[1];
		evt.sck_fall = held[1] & ~filt[1];
		evt.mosi     = filt[2];
	end

endmodule

`default_nettype wire

// ==== source/spi_ctrl_pkg.sv ====
// shared frame constants and bus structs for the mode 0 control port, one fixed device id
`default_nettype none

package spi_ctrl_pkg;

	// ----------------------------------------
	// frame constants

	// identifier returned at address 0 and at frame start
	localparam logic [7:0] DEV_ID = 8'hA5;

	// write flag position in the command byte
	localparam int CMD_WRITE_BIT = 7;

	// register map
	localparam logic [1:0] ADDR_ID    = 2'd0;
	localparam logic [1:0] ADDR_CTRL1 = 2'd1;
	localparam logic [1:0] ADDR_CTRL2 = 2'd2;
	localparam logic [1:0] ADDR_CTRL3 = 2'd3;

	// ----------------------------------------
	// buses between the stages

	// filtered pins and edge strobes
	typedef struct packed {
		logic csn;
		logic csn_fall;
		logic sck_rise;
		logic sck_fall;
		logic mosi;
	} pin_evt_t;

	// received byte, vld is a one cycle strobe
	typedef struct packed {
		logic       vld;
		logic       first;
		logic [7:0] data;
	} rx_byte_t;

	typedef struct packed {
		logic [7:0] ctrl1;
		logic [7:0] ctrl2;
		logic [7:0] ctrl3;
	} ctrl_regs_t;

endpackage

`default_nettype wire
